// ==== rtl/frame_buf_pkg.sv ====
package frame_buf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    // one frame byte per beat
    localparam int DATA_W     = 8;
    // frame ring storage
    localparam int RAM_DEPTH  = 2048;
    localparam int ADDR_W     = 11;
    // frame length up to a full ring
    localparam int LEN_W      = 12;

    // descriptor queue
    localparam int DESC_DEPTH = 16;
    localparam int DESC_AW    = 4;

    // output credit counter
    localparam int CREDIT_MAX = 15;
    localparam int CREDIT_W   = 4;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [47:0]       mac_t;
    typedef logic [1:0]        frag_idx_t;
    // bit 0 crc valid, bit 1 mcrc valid
    typedef logic [1:0]        crc_flags_t;

    // only frames to this station are kept
    localparam mac_t STATION_MAC = 48'h00_00_00_ff_ff_ff;

    // smd start codes
    localparam byte_t SMD_S0 = 8'he6;
    localparam byte_t SMD_S1 = 8'h4c;
    localparam byte_t SMD_S2 = 8'h7f;
    localparam byte_t SMD_S3 = 8'hb3;

    // fragment count codes
    localparam byte_t FRAG_C0 = 8'he6;
    localparam byte_t FRAG_C1 = 8'h4c;
    localparam byte_t FRAG_C2 = 8'h7f;
    localparam byte_t FRAG_C3 = 8'hb3;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // per-frame info, 12 bits
    typedef struct packed {
        byte_t      smd_type;
        frag_idx_t  frag_idx;
        crc_flags_t crc_flags;
    } frame_info_t;

    // queued frame, 34 bits
    typedef struct packed {
        frame_info_t info;
        addr_t       first_addr;
        addr_t       last_addr;
    } frame_desc_t;

    // output beat, 9 bits
    typedef struct packed {
        byte_t data;
        logic  last;
    } out_beat_t;

    // read side fsm
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOAD,
        RD_STREAM,
        RD_DONE
    } rd_state_t;

endpackage

// ==== rtl/frame_meta_capture.sv ====
`timescale 1ns/10ps

module frame_meta_capture (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  frame_buf_pkg::mac_t        i_target_mac,
    input  logic                       i_target_mac_valid,
    input  frame_buf_pkg::byte_t       i_smd_type,
    input  logic                       i_smd_type_vld,
    input  frame_buf_pkg::byte_t       i_frag_cnt,
    input  logic                       i_frag_cnt_vld,
    input  logic                       i_post_last,
    input  frame_buf_pkg::crc_flags_t  i_crc_vld,
    output frame_buf_pkg::frame_info_t o_info,
    output logic                       o_mac_match
);

    frame_buf_pkg::mac_t       r_target_mac;
    frame_buf_pkg::byte_t      r_smd_type;
    frame_buf_pkg::frag_idx_t  r_frag_idx;
    frame_buf_pkg::crc_flags_t r_crc_flags;
    logic                      smd_start;

    // start code restarts the fragment sequence
    assign smd_start = i_smd_type_vld && (i_smd_type inside {
        frame_buf_pkg::SMD_S0, frame_buf_pkg::SMD_S1,
        frame_buf_pkg::SMD_S2, frame_buf_pkg::SMD_S3});

    // header fields, held until the next pulse
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_target_mac <= '0;
            r_smd_type   <= '0;
            r_crc_flags  <= '0;
        end else begin
            if (i_target_mac_valid) begin
                r_target_mac <= i_target_mac;
            end
            if (i_smd_type_vld) begin
                r_smd_type <= i_smd_type;
            end
            // crc result shows up with the last byte
            if (i_post_last) begin
                r_crc_flags <= i_crc_vld;
            end
        end
    end

    // fragment code to 2-bit index
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_frag_idx <= '0;
        end else if (smd_start) begin
            r_frag_idx <= '0;
        end else if (i_frag_cnt_vld) begin
            case (i_frag_cnt)
                frame_buf_pkg::FRAG_C0: r_frag_idx <= 2'd0;
                frame_buf_pkg::FRAG_C1: r_frag_idx <= 2'd1;
                frame_buf_pkg::FRAG_C2: r_frag_idx <= 2'd2;
                frame_buf_pkg::FRAG_C3: r_frag_idx <= 2'd3;
                // unknown code keeps the old index
                default:                r_frag_idx <= r_frag_idx;
            endcase
        end
    end

    assign o_info.smd_type  = r_smd_type;
    assign o_info.frag_idx  = r_frag_idx;
    // pass flags straight through on the last byte so the descriptor sees them
    assign o_info.crc_flags = i_post_last ? i_crc_vld : r_crc_flags;

    assign o_mac_match = (r_target_mac == frame_buf_pkg::STATION_MAC);

endmodule

// ==== rtl/frame_write_ctrl.sv ====
`timescale 1ns/10ps

module frame_write_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  frame_buf_pkg::byte_t       i_post_data,
    input  logic                       i_post_data_vld,
    input  logic                       i_post_last,
    input  logic                       i_crc_err,
    input  frame_buf_pkg::frame_info_t i_info,
    input  logic                       i_mac_match,
    input  logic                       i_fifo_full,
    output frame_buf_pkg::addr_t       o_wr_addr,
    output frame_buf_pkg::byte_t       o_wr_data,
    output logic                       o_wr_en,
    output logic                       o_push,
    output frame_buf_pkg::frame_desc_t o_desc
);

    // address the current input byte lands on
    frame_buf_pkg::addr_t wr_ptr;
    // first address of the frame in progress
    frame_buf_pkg::addr_t r_first;
    frame_buf_pkg::addr_t frame_first;
    logic                 in_frame;
    logic                 last_byte;
    logic                 accept;

    assign last_byte = i_post_data_vld && i_post_last;

    // a one-byte frame starts and ends in the same cycle
    assign frame_first = in_frame ? r_first : wr_ptr;

    // commit rule
    assign accept = i_mac_match && !i_crc_err && !i_fifo_full;

    ////////////////////////////////////////////////////////////////////////////
    // write pointer and frame tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            r_first  <= '0;
            in_frame <= 1'b0;
        end else if (i_post_data_vld) begin
            if (!in_frame) begin
                r_first <= wr_ptr;
            end
            // dropped frame gives its space back
            if (last_byte && !accept) begin
                wr_ptr <= frame_first;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            in_frame <= !i_post_last;
        end
    end

    // ram write port, one cycle behind the input
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_post_data_vld;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wr_addr <= wr_ptr;
        o_wr_data <= i_post_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // descriptor push
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_push <= 1'b0;
        end else begin
            o_push <= last_byte && accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (last_byte) begin
            o_desc.info       <= i_info;
            o_desc.first_addr <= frame_first;
            o_desc.last_addr  <= wr_ptr;
        end
    end

endmodule

// ==== rtl/frame_ram.sv ====
`timescale 1ns/10ps

module frame_ram (
    input  logic                 i_clk,
    input  logic                 i_wr_en,
    input  frame_buf_pkg::addr_t i_wr_addr,
    input  frame_buf_pkg::byte_t i_wr_data,
    input  logic                 i_rd_en,
    input  frame_buf_pkg::addr_t i_rd_addr,
    output frame_buf_pkg::byte_t o_rd_data
);

    // byte ring, wraps with the address width
    frame_buf_pkg::byte_t mem [frame_buf_pkg::RAM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // data valid one cycle after the read enable
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

// ==== rtl/desc_fifo.sv ====
`timescale 1ns/10ps

module desc_fifo (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_push,
    input  frame_buf_pkg::frame_desc_t i_desc,
    input  logic                       i_pop,
    output frame_buf_pkg::frame_desc_t o_head,
    output logic                       o_empty,
    output logic                       o_full
);

    frame_buf_pkg::frame_desc_t mem [frame_buf_pkg::DESC_DEPTH];

    logic [frame_buf_pkg::DESC_AW-1:0] wr_ptr;
    logic [frame_buf_pkg::DESC_AW-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [frame_buf_pkg::DESC_AW:0]   count;

    // storage
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_desc;
        end
    end

    // pointers and fill level
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through head
    assign o_head  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == (frame_buf_pkg::DESC_AW + 1)'(frame_buf_pkg::DESC_DEPTH));

endmodule

// ==== rtl/frame_read_ctrl.sv ====
`timescale 1ns/10ps

module frame_read_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  frame_buf_pkg::frame_desc_t i_head,
    input  logic                       i_empty,
    input  logic                       i_credit,
    input  frame_buf_pkg::byte_t       i_rd_data,
    output logic                       o_pop,
    output logic                       o_rd_en,
    output frame_buf_pkg::addr_t       o_rd_addr,
    output frame_buf_pkg::out_beat_t   o_beat,
    output logic                       o_valid,
    output frame_buf_pkg::frame_info_t o_user,
    output frame_buf_pkg::len_t        o_len
);

    frame_buf_pkg::rd_state_t           state;
    logic [frame_buf_pkg::CREDIT_W-1:0] credit;
    frame_buf_pkg::addr_t               rd_addr;
    frame_buf_pkg::addr_t               last_addr;
    logic                               rd_issue;
    logic                               rd_last;
    logic                               credit_inc;
    // read enable and last flag lined up with ram data
    logic                               r_rd_vld;
    logic                               r_rd_last;

    // one read per credit
    assign rd_issue   = (state == frame_buf_pkg::RD_STREAM) && (credit != '0);
    assign rd_last    = rd_issue && (rd_addr == last_addr);
    assign credit_inc = i_credit &&
        (credit != frame_buf_pkg::CREDIT_W'(frame_buf_pkg::CREDIT_MAX));

    assign o_pop     = (state == frame_buf_pkg::RD_LOAD);
    assign o_rd_en   = rd_issue;
    assign o_rd_addr = rd_addr;

    ////////////////////////////////////////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            credit <= '0;
        end else begin
            // saturates at the top, a read spends one
            case ({credit_inc, rd_issue})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= frame_buf_pkg::RD_IDLE;
            rd_addr   <= '0;
            last_addr <= '0;
            o_user    <= '0;
            o_len     <= '0;
        end else begin
            case (state)
                // wait for a committed frame
                frame_buf_pkg::RD_IDLE: begin
                    if (!i_empty) begin
                        state <= frame_buf_pkg::RD_LOAD;
                    end
                end
                // take the head, pop fires this cycle
                frame_buf_pkg::RD_LOAD: begin
                    rd_addr   <= i_head.first_addr;
                    last_addr <= i_head.last_addr;
                    o_user    <= i_head.info;
                    // length modulo the ring
                    o_len     <= frame_buf_pkg::len_t'(frame_buf_pkg::addr_t'(
                                 i_head.last_addr - i_head.first_addr)) + 1'b1;
                    state     <= frame_buf_pkg::RD_STREAM;
                end
                // walk the frame while credit lasts
                frame_buf_pkg::RD_STREAM: begin
                    if (rd_issue) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (rd_last) begin
                            state <= frame_buf_pkg::RD_DONE;
                        end
                    end
                end
                // final beat leaves the ram here
                frame_buf_pkg::RD_DONE: begin
                    state <= frame_buf_pkg::RD_IDLE;
                end
                default: begin
                    state <= frame_buf_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // one cycle delay to match the ram read
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_rd_vld  <= 1'b0;
            r_rd_last <= 1'b0;
        end else begin
            r_rd_vld  <= rd_issue;
            r_rd_last <= rd_last;
        end
    end

    assign o_valid     = r_rd_vld;
    // zero data between beats
    assign o_beat.data = r_rd_vld ? i_rd_data : '0;
    assign o_beat.last = r_rd_last;

endmodule

// ==== rtl/frame_buf_top.sv ====
`timescale 1ns/10ps

module frame_buf_top (
    input  logic                       i_clk,
    input  logic                       i_rst,
    // frame parser side
    input  frame_buf_pkg::byte_t       i_post_data,
    input  logic                       i_post_data_vld,
    input  logic                       i_post_last,
    input  frame_buf_pkg::crc_flags_t  i_crc_vld,
    input  logic                       i_crc_err,
    input  frame_buf_pkg::mac_t        i_target_mac,
    input  logic                       i_target_mac_valid,
    input  frame_buf_pkg::byte_t       i_smd_type,
    input  logic                       i_smd_type_vld,
    input  frame_buf_pkg::byte_t       i_frag_cnt,
    input  logic                       i_frag_cnt_vld,
    // downstream side
    input  logic                       i_credit,
    output frame_buf_pkg::out_beat_t   o_beat,
    output logic                       o_valid,
    output frame_buf_pkg::frame_info_t o_user,
    output frame_buf_pkg::len_t        o_len
);

    // metadata to write side
    frame_buf_pkg::frame_info_t info;
    logic                       mac_match;

    // ram ports
    frame_buf_pkg::addr_t       wr_addr;
    frame_buf_pkg::byte_t       wr_data;
    logic                       wr_en;
    frame_buf_pkg::addr_t       rd_addr;
    frame_buf_pkg::byte_t       rd_data;
    logic                       rd_en;

    // descriptor queue
    frame_buf_pkg::frame_desc_t push_desc;
    frame_buf_pkg::frame_desc_t head;
    logic                       push;
    logic                       pop;
    logic                       empty;
    logic                       full;

    frame_meta_capture u_meta (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_target_mac       (i_target_mac),
        .i_target_mac_valid (i_target_mac_valid),
        .i_smd_type         (i_smd_type),
        .i_smd_type_vld     (i_smd_type_vld),
        .i_frag_cnt         (i_frag_cnt),
        .i_frag_cnt_vld     (i_frag_cnt_vld),
        .i_post_last        (i_post_last),
        .i_crc_vld          (i_crc_vld),
        .o_info             (info),
        .o_mac_match        (mac_match)
    );

    frame_write_ctrl u_wr_ctrl (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_post_data     (i_post_data),
        .i_post_data_vld (i_post_data_vld),
        .i_post_last     (i_post_last),
        .i_crc_err       (i_crc_err),
        .i_info          (info),
        .i_mac_match     (mac_match),
        .i_fifo_full     (full),
        .o_wr_addr       (wr_addr),
        .o_wr_data       (wr_data),
        .o_wr_en         (wr_en),
        .o_push          (push),
        .o_desc          (push_desc)
    );

    frame_ram u_ram (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    desc_fifo u_desc_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (push),
        .i_desc  (push_desc),
        .i_pop   (pop),
        .o_head  (head),
        .o_empty (empty),
        .o_full  (full)
    );

    frame_read_ctrl u_rd_ctrl (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_head    (head),
        .i_empty   (empty),
        .i_credit  (i_credit),
        .i_rd_data (rd_data),
        .o_pop     (pop),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .o_beat    (o_beat),
        .o_valid   (o_valid),
        .o_user    (o_user),
        .o_len     (o_len)
    );

endmodule

// ==== verif/tb_frame_buf_cases.svh ====
// columns: name, length in bytes, target mac, smd code, fragment code,
// crc flags {mcrc, crc}, crc error on the last byte
// payload bytes come from the seeded random stream, not from this table

typedef struct packed {
    logic [6:0]                len;
    frame_buf_pkg::mac_t       mac;
    frame_buf_pkg::byte_t      smd;
    frame_buf_pkg::byte_t      frag;
    frame_buf_pkg::crc_flags_t crc_flags;
    logic                      crc_err;
} frame_case_t;

// station address and a few that must be dropped
localparam frame_buf_pkg::mac_t OWN_MAC   = frame_buf_pkg::STATION_MAC;
localparam frame_buf_pkg::mac_t NEAR_MAC  = 48'h00_00_00_ff_ff_fe;
localparam frame_buf_pkg::mac_t BCAST_MAC = 48'hff_ff_ff_ff_ff_ff;

frame_case_t case_tbl [$];
string       case_name [$];

task automatic add_case(
    input string                     name,
    input int                        len,
    input frame_buf_pkg::mac_t       mac,
    input frame_buf_pkg::byte_t      smd,
    input frame_buf_pkg::byte_t      frag,
    input frame_buf_pkg::crc_flags_t crc_flags,
    input logic                      crc_err
);
    frame_case_t c;
    c.len       = 7'(len);
    c.mac       = mac;
    c.smd       = smd;
    c.frag      = frag;
    c.crc_flags = crc_flags;
    c.crc_err   = crc_err;
    case_tbl.push_back(c);
    case_name.push_back(name);
endtask

// first four rows run with credit held off
task automatic load_cases();
    add_case("single_byte",     1,  OWN_MAC,   8'he6, 8'h4c, 2'b01, 1'b0);
    add_case("short_frame",     8,  OWN_MAC,   8'hd5, 8'h4c, 2'b11, 1'b0);
    add_case("bad_mac",         20, NEAR_MAC,  8'hd5, 8'h7f, 2'b01, 1'b0);
    add_case("after_bad_mac",   16, OWN_MAC,   8'h55, 8'h7f, 2'b01, 1'b0);
    add_case("crc_error",       33, OWN_MAC,   8'h55, 8'hb3, 2'b00, 1'b1);
    add_case("after_crc_error", 5,  OWN_MAC,   8'h4c, 8'hb3, 2'b11, 1'b0);
    add_case("frag_c3",         64, OWN_MAC,   8'h55, 8'hb3, 2'b01, 1'b0);
    add_case("frag_c0",         12, OWN_MAC,   8'haa, 8'he6, 2'b10, 1'b0);
    add_case("bcast_mac",       10, BCAST_MAC, 8'haa, 8'h4c, 2'b01, 1'b0);
    add_case("mcrc_only",       40, OWN_MAC,   8'h7f, 8'h4c, 2'b10, 1'b0);
    add_case("tail_short",      2,  OWN_MAC,   8'hd5, 8'h7f, 2'b01, 1'b0);
    add_case("frag_unknown",    24, OWN_MAC,   8'hd5, 8'h00, 2'b11, 1'b0);
    add_case("long_run",        64, OWN_MAC,   8'hb3, 8'h7f, 2'b01, 1'b0);
endtask

// ==== verif/tb_frame_buf.sv ====
`timescale 1ns/10ps

module tb_frame_buf;

    // frames driven before credit is switched on
    localparam int HOLD_CASES    = 4;
    localparam int DRAIN_TIMEOUT = 5000;
    localparam int SETTLE_CYCLES = 30;

    logic                       i_clk;
    logic                       i_rst;
    frame_buf_pkg::byte_t       i_post_data;
    logic                       i_post_data_vld;
    logic                       i_post_last;
    frame_buf_pkg::crc_flags_t  i_crc_vld;
    logic                       i_crc_err;
    frame_buf_pkg::mac_t        i_target_mac;
    logic                       i_target_mac_valid;
    frame_buf_pkg::byte_t       i_smd_type;
    logic                       i_smd_type_vld;
    frame_buf_pkg::byte_t       i_frag_cnt;
    logic                       i_frag_cnt_vld;
    logic                       i_credit;
    frame_buf_pkg::out_beat_t   o_beat;
    logic                       o_valid;
    frame_buf_pkg::frame_info_t o_user;
    frame_buf_pkg::len_t        o_len;

    // expected output, per beat and per frame
    frame_buf_pkg::out_beat_t   exp_beats [$];
    frame_buf_pkg::frame_info_t exp_info [$];
    frame_buf_pkg::len_t        exp_len [$];
    string                      exp_name [$];

    // running model of the fragment index
    frame_buf_pkg::frag_idx_t   frag_model;
    logic                       credit_on;
    int                         mismatch_cnt;
    int                         fail_cnt;
    int                         credits_given;
    int                         beats_seen;
    int                         frames_seen;
    int                         frames_expected;

    `include "tb_frame_buf_cases.svh"

    frame_buf_top uut (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_post_data        (i_post_data),
        .i_post_data_vld    (i_post_data_vld),
        .i_post_last        (i_post_last),
        .i_crc_vld          (i_crc_vld),
        .i_crc_err          (i_crc_err),
        .i_target_mac       (i_target_mac),
        .i_target_mac_valid (i_target_mac_valid),
        .i_smd_type         (i_smd_type),
        .i_smd_type_vld     (i_smd_type_vld),
        .i_frag_cnt         (i_frag_cnt),
        .i_frag_cnt_vld     (i_frag_cnt_vld),
        .i_credit           (i_credit),
        .o_beat             (o_beat),
        .o_valid            (o_valid),
        .o_user             (o_user),
        .o_len              (o_len)
    );

    // 40 ns clock
    always #20 i_clk = ~i_clk;

    // random credit pulses, about two cycles in three
    always @(posedge i_clk) begin
        #2;
        i_credit = credit_on && (($urandom % 3) != 0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////////////////////

    // smd values that restart the fragment count
    function automatic logic is_start_code(input frame_buf_pkg::byte_t code);
        return (code == 8'he6) || (code == 8'h4c) || (code == 8'h7f) || (code == 8'hb3);
    endfunction

    // fragment code to index, unknown codes keep the old one
    function automatic frame_buf_pkg::frag_idx_t frag_index(
        input frame_buf_pkg::byte_t     code,
        input frame_buf_pkg::frag_idx_t prev
    );
        case (code)
            8'he6:   return 2'd0;
            8'h4c:   return 2'd1;
            8'h7f:   return 2'd2;
            8'hb3:   return 2'd3;
            default: return prev;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_beat(input string name, input frame_buf_pkg::out_beat_t exp,
                              input frame_buf_pkg::out_beat_t act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("mismatch %s beat: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_info(input string name, input frame_buf_pkg::frame_info_t exp,
                              input frame_buf_pkg::frame_info_t act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("mismatch %s user: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input frame_buf_pkg::len_t exp,
                             input frame_buf_pkg::len_t act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("mismatch %s len: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            mismatch_cnt++;
            $display("mismatch %s valid: expected %b actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // frame driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_frame(input int idx);
        frame_case_t                c;
        frame_buf_pkg::byte_t       payload [$];
        frame_buf_pkg::frame_info_t info;
        frame_buf_pkg::out_beat_t   beat;
        int                         n;
        logic                       keep;
        c = case_tbl[idx];
        n = int'(c.len);
        for (int b = 0; b < n; b++) begin
            payload.push_back(frame_buf_pkg::byte_t'($urandom));
        end
        // frag pulse goes first, so a later start code clears it
        frag_model = frag_index(c.frag, frag_model);
        if (is_start_code(c.smd)) begin
            frag_model = '0;
        end
        info.smd_type  = c.smd;
        info.frag_idx  = frag_model;
        info.crc_flags = c.crc_flags;
        // commit rule, the fifo never fills with this table
        keep = (c.mac == frame_buf_pkg::STATION_MAC) && !c.crc_err;
        if (keep) begin
            for (int b = 0; b < n; b++) begin
                beat.data = payload[b];
                beat.last = (b == n - 1);
                exp_beats.push_back(beat);
            end
            exp_info.push_back(info);
            exp_len.push_back(frame_buf_pkg::len_t'(n));
            exp_name.push_back(case_name[idx]);
            frames_expected++;
        end
        // header pulses ahead of the bytes
        @(posedge i_clk);
        #2;
        i_target_mac       = c.mac;
        i_target_mac_valid = 1'b1;
        i_frag_cnt         = c.frag;
        i_frag_cnt_vld     = 1'b1;
        @(posedge i_clk);
        #2;
        i_target_mac_valid = 1'b0;
        i_frag_cnt_vld     = 1'b0;
        i_smd_type         = c.smd;
        i_smd_type_vld     = 1'b1;
        // one byte per cycle, crc status rides on the last
        for (int b = 0; b < n; b++) begin
            @(posedge i_clk);
            #2;
            i_smd_type_vld  = 1'b0;
            i_post_data     = payload[b];
            i_post_data_vld = 1'b1;
            i_post_last     = (b == n - 1);
            i_crc_vld       = (b == n - 1) ? c.crc_flags : 2'b00;
            i_crc_err       = (b == n - 1) && c.crc_err;
        end
        @(posedge i_clk);
        #2;
        i_post_data_vld = 1'b0;
        i_post_last     = 1'b0;
        i_crc_vld       = 2'b00;
        i_crc_err       = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, samples mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (i_credit) begin
                credits_given++;
            end
            if (o_valid) begin
                beats_seen++;
                if (beats_seen > credits_given) begin
                    fail_cnt++;
                    $display("more output beats (%0d) than credits granted (%0d)",
                             beats_seen, credits_given);
                end
                if (exp_beats.size() == 0) begin
                    fail_cnt++;
                    $display("output beat %h arrived when no frame was expected", o_beat);
                end else begin
                    check_beat(exp_name[0], exp_beats[0], o_beat);
                    check_info(exp_name[0], exp_info[0], o_user);
                    check_len(exp_name[0], exp_len[0], o_len);
                    // frame ends, move to the next one
                    if (exp_beats[0].last) begin
                        void'(exp_info.pop_front());
                        void'(exp_len.pop_front());
                        void'(exp_name.pop_front());
                        frames_seen++;
                    end
                    void'(exp_beats.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int wait_cycles;
        i_clk              = 1'b0;
        i_rst              = 1'b1;
        i_post_data        = '0;
        i_post_data_vld    = 1'b0;
        i_post_last        = 1'b0;
        i_crc_vld          = '0;
        i_crc_err          = 1'b0;
        i_target_mac       = '0;
        i_target_mac_valid = 1'b0;
        i_smd_type         = '0;
        i_smd_type_vld     = 1'b0;
        i_frag_cnt         = '0;
        i_frag_cnt_vld     = 1'b0;
        i_credit           = 1'b0;
        credit_on          = 1'b0;
        frag_model         = '0;
        mismatch_cnt       = 0;
        fail_cnt           = 0;
        credits_given      = 0;
        beats_seen         = 0;
        frames_seen        = 0;
        frames_expected    = 0;
        void'($urandom(32'hcbc6dbf2));
        load_cases();

        repeat (3) @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        // quiet outputs before any credit or frame
        repeat (4) begin
            @(negedge i_clk);
            check_flag("reset_idle", 1'b0, o_valid);
            check_info("reset_idle", '0, o_user);
            check_len("reset_idle", '0, o_len);
        end

        for (int i = 0; i < case_tbl.size(); i++) begin
            if (i == HOLD_CASES) begin
                // committed frames sit in the fifo until credit arrives
                if (beats_seen != 0) begin
                    fail_cnt++;
                    $display("output moved with no credit, %0d beats seen", beats_seen);
                end
                credit_on = 1'b1;
            end
            drive_frame(i);
        end

        // drain the queued frames
        wait_cycles = 0;
        while ((exp_beats.size() != 0) && (wait_cycles < DRAIN_TIMEOUT)) begin
            @(posedge i_clk);
            wait_cycles++;
        end
        if (exp_beats.size() != 0) begin
            fail_cnt++;
            $display("timed out after %0d cycles with %0d frames not received",
                     DRAIN_TIMEOUT, exp_info.size());
        end
        // stray beats from dropped frames would show up here
        repeat (SETTLE_CYCLES) @(posedge i_clk);

        $display("errors: %0d mismatches, %0d other failures, %0d of %0d frames received",
                 mismatch_cnt, fail_cnt, frames_seen, frames_expected);
        if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verif
rtl/frame_buf_pkg.sv
rtl/frame_meta_capture.sv
rtl/frame_write_ctrl.sv
rtl/frame_ram.sv
rtl/desc_fifo.sv
rtl/frame_read_ctrl.sv
rtl/frame_buf_top.sv
verif/tb_frame_buf.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frame_buf
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
